// ==== Bender.yml ====
package:
  name: instrController

sources:
  - common/ctrlPkg.sv
  - src/instrDecoder.sv
  - src/condEvaluator.sv
  - sequencer/ctrlSequencer.sv
  - src/instrController.sv
  - target: simulation
    files:
      - verification/ctrlChecker.sv
      - verification/tbInstrController.sv

// ==== common/ctrlPkg.sv ====
package ctrlPkg;

    typedef logic [3:0] opcode_t;
    typedef logic [3:0] condCode_t;
    typedef logic [1:0] aluSrcSel_t;
    typedef logic [1:0] pcSrc_t;

    // processor status register as the datapath holds it
    typedef struct packed {
        logic [2:0] unused;
        logic       carry;    // C
        logic       low;      // L, unsigned compare
        logic       flag;     // F
        logic       zero;     // Z
        logic       negative; // N, signed compare
    } psrFlags_t;

    typedef struct packed {
        logic       memWrite;
        logic       pcEn;
        logic       writeBackSelect;   // memory data to register file
        logic       dataToWriteSelect; // link address to register file
        logic       newAluInput;
        logic       psrRegEn;
        logic       regWrite;
        logic       instrWrite;
        aluSrcSel_t aluSrc1Sel;
        aluSrcSel_t aluSrc2Sel;
        pcSrc_t     pcSrc;
    } ctrlSignals_t;

    typedef enum logic [3:0] {
        ALU_REG, ALU_IMM, CMP_REG, CMP_IMM, MOV_REG, MOV_IMM,
        LOAD, STOR, JAL, JCOND, BCOND, NOP
    } instrClass_t;

    typedef enum logic [3:0] {
        FETCH, DECODE, LOAD_OPERANDS, ALU_EXECUTE, WRITEBACK,
        MEM_ADDR, MEM_READ, MEM_WRITE, LOAD_WRITEBACK,
        JAL_READ, JAL_LINK, JAL_TARGET, TRANSFER, PC_INCR, PC_WAIT
    } ctrlState_t;

    // alu operand and pc source selects
    localparam aluSrcSel_t SRC1_PC   = 2'd0;
    localparam aluSrcSel_t SRC1_REG  = 2'd1;
    localparam aluSrcSel_t SRC1_ZERO = 2'd2;
    localparam aluSrcSel_t SRC2_REG  = 2'd0;
    localparam aluSrcSel_t SRC2_IMM  = 2'd1;
    localparam pcSrc_t     PC_SEQ    = 2'd0;
    localparam pcSrc_t     PC_ABS    = 2'd1;
    localparam pcSrc_t     PC_REL    = 2'd2;

    // primary opcodes
    localparam opcode_t OP_REG   = 4'd0;
    localparam opcode_t OP_ANDI  = 4'd1;
    localparam opcode_t OP_ORI   = 4'd2;
    localparam opcode_t OP_XORI  = 4'd3;
    localparam opcode_t OP_MEM   = 4'd4;
    localparam opcode_t OP_ADDI  = 4'd5;
    localparam opcode_t OP_SHIFT = 4'd8;
    localparam opcode_t OP_SUBI  = 4'd9;
    localparam opcode_t OP_CMPI  = 4'd11;
    localparam opcode_t OP_BCOND = 4'd12;
    localparam opcode_t OP_MOVI  = 4'd13;
    localparam opcode_t OP_LUI   = 4'd15;

    // extensions under OP_REG
    localparam opcode_t EXT_AND = 4'd1;
    localparam opcode_t EXT_OR  = 4'd2;
    localparam opcode_t EXT_XOR = 4'd3;
    localparam opcode_t EXT_ADD = 4'd5;
    localparam opcode_t EXT_SUB = 4'd9;
    localparam opcode_t EXT_CMP = 4'd11;
    localparam opcode_t EXT_MOV = 4'd13;

    localparam opcode_t EXT_LSH = 4'd4; // under OP_SHIFT, anything else is LSHI

    // extensions under OP_MEM
    localparam opcode_t EXT_LOAD  = 4'd0;
    localparam opcode_t EXT_STOR  = 4'd4;
    localparam opcode_t EXT_JAL   = 4'd8;
    localparam opcode_t EXT_JCOND = 4'd12;

    localparam condCode_t COND_EQ    = 4'd0;
    localparam condCode_t COND_NE    = 4'd1;
    localparam condCode_t COND_CS    = 4'd2;
    localparam condCode_t COND_CC    = 4'd3;
    localparam condCode_t COND_HI    = 4'd4;
    localparam condCode_t COND_LS    = 4'd5;
    localparam condCode_t COND_GT    = 4'd6;
    localparam condCode_t COND_LE    = 4'd7;
    localparam condCode_t COND_FS    = 4'd8;
    localparam condCode_t COND_FC    = 4'd9;
    localparam condCode_t COND_LO    = 4'd10;
    localparam condCode_t COND_HS    = 4'd11;
    localparam condCode_t COND_LT    = 4'd12;
    localparam condCode_t COND_GE    = 4'd13;
    localparam condCode_t COND_UC    = 4'd14;
    localparam condCode_t COND_NEVER = 4'd15;

endpackage

// ==== instrController.f ====
common/ctrlPkg.sv
src/instrDecoder.sv
src/condEvaluator.sv
sequencer/ctrlSequencer.sv
src/instrController.sv
verification/ctrlChecker.sv
verification/tbInstrController.sv

// ==== sequencer/ctrlSequencer.sv ====
module ctrlSequencer #(
    parameter int PcWaitStates = 2
) (
    input  logic                  clk,
    input  logic                  reset,
    input  ctrlPkg::instrClass_t  instrClass,
    input  logic                  condTrue,
    output ctrlPkg::ctrlSignals_t ctrl
);
    import ctrlPkg::*;

    localparam int WaitWidth = (PcWaitStates > 1) ? $clog2(PcWaitStates) : 1;
    localparam logic [WaitWidth-1:0] LastWait = WaitWidth'(PcWaitStates - 1);
    // skip the idle cycles entirely when no memory latency is configured
    localparam ctrlState_t AfterPcUpdate = (PcWaitStates > 0) ? PC_WAIT : FETCH;

    ctrlState_t           state;
    ctrlState_t           nextState;
    logic [WaitWidth-1:0] waitCount;
    logic                 isCompare;
    logic                 isMove;
    logic                 isImmediate;

    assign isCompare   = (instrClass == CMP_REG) || (instrClass == CMP_IMM);
    assign isMove      = (instrClass == MOV_REG) || (instrClass == MOV_IMM);
    assign isImmediate = (instrClass == ALU_IMM) || (instrClass == CMP_IMM) ||
                         (instrClass == MOV_IMM);

    always_ff @(posedge clk)
    begin
        if (!reset)
            state <= FETCH;
        else
            state <= nextState;
    end

    always_ff @(posedge clk)
    begin
        if (!reset)
            waitCount <= '0;
        else if (state == PC_WAIT)
            waitCount <= waitCount + 1'b1;
        else
            waitCount <= '0;
    end

    always_comb
    begin
        nextState = FETCH;
        case (state)
            FETCH: nextState = DECODE;
            DECODE:
                case (instrClass)
                    ALU_REG, ALU_IMM, CMP_REG, CMP_IMM, MOV_REG, MOV_IMM:
                        nextState = LOAD_OPERANDS;
                    LOAD, STOR:    nextState = MEM_ADDR;
                    JAL:           nextState = JAL_READ;
                    JCOND, BCOND:  nextState = TRANSFER;
                    default:       nextState = PC_INCR;
                endcase
            LOAD_OPERANDS:  nextState = ALU_EXECUTE;
            ALU_EXECUTE:    nextState = isCompare ? PC_INCR : WRITEBACK; // flags only
            WRITEBACK:      nextState = PC_INCR;
            MEM_ADDR:       nextState = (instrClass == STOR) ? MEM_WRITE : MEM_READ;
            MEM_READ:       nextState = LOAD_WRITEBACK;
            MEM_WRITE:      nextState = PC_INCR;
            LOAD_WRITEBACK: nextState = PC_INCR;
            JAL_READ:       nextState = JAL_LINK;
            JAL_LINK:       nextState = JAL_TARGET;
            JAL_TARGET:     nextState = PC_INCR;
            TRANSFER:       nextState = AfterPcUpdate;
            PC_INCR:        nextState = AfterPcUpdate;
            PC_WAIT:        nextState = (waitCount == LastWait) ? FETCH : PC_WAIT;
            default:        nextState = FETCH;
        endcase
    end

    always_comb
    begin
        ctrl            = '0;
        ctrl.aluSrc1Sel = SRC1_PC;
        ctrl.aluSrc2Sel = SRC2_REG;
        ctrl.pcSrc      = PC_SEQ;
        case (state)
            FETCH: ctrl.instrWrite = 1'b1;
            LOAD_OPERANDS, MEM_ADDR, JAL_READ: ctrl.newAluInput = 1'b1;
            ALU_EXECUTE:
            begin
                ctrl.aluSrc1Sel = isMove ? SRC1_ZERO : SRC1_REG; // mov adds to zero
                ctrl.aluSrc2Sel = isImmediate ? SRC2_IMM : SRC2_REG;
                ctrl.psrRegEn   = isCompare;
            end
            WRITEBACK: ctrl.regWrite = 1'b1;
            MEM_WRITE: ctrl.memWrite = 1'b1;
            LOAD_WRITEBACK:
            begin
                ctrl.regWrite        = 1'b1;
                ctrl.writeBackSelect = 1'b1;
            end
            JAL_LINK:
            begin
                ctrl.regWrite          = 1'b1;
                ctrl.dataToWriteSelect = 1'b1;
            end
            JAL_TARGET:
            begin
                ctrl.pcEn  = 1'b1;
                ctrl.pcSrc = PC_ABS;
            end
            PC_INCR: ctrl.pcEn = 1'b1;
            TRANSFER:
            begin
                // not taken still writes pc, with the sequential source
                ctrl.pcEn = 1'b1;
                if (condTrue)
                    ctrl.pcSrc = (instrClass == JCOND) ? PC_ABS : PC_REL;
            end
            default: ctrl = ctrl;
        endcase
    end

    noRegAndMemWrite: assert property (@(posedge clk) disable iff (!reset)
        !(ctrl.regWrite && ctrl.memWrite));

    noPcWriteInFetch: assert property (@(posedge clk) disable iff (!reset)
        (state == FETCH) |-> !ctrl.pcEn);

endmodule

// ==== src/condEvaluator.sv ====
module condEvaluator (
    input  ctrlPkg::condCode_t condCode,
    input  ctrlPkg::psrFlags_t psr,
    output logic               condTrue
);
    import ctrlPkg::*;

    always_comb
    begin
        case (condCode)
            COND_EQ: condTrue = psr.zero;
            COND_NE: condTrue = !psr.zero;
            COND_GE: condTrue = psr.zero || psr.negative;
            COND_CS: condTrue = psr.carry;
            COND_CC: condTrue = !psr.carry;
            COND_HI: condTrue = psr.low;
            COND_LS: condTrue = !psr.low;
            COND_LO: condTrue = !psr.low && !psr.zero;
            COND_HS: condTrue = psr.low || psr.zero;
            COND_GT: condTrue = psr.negative;
            COND_LE: condTrue = !psr.negative;
            COND_FS: condTrue = psr.flag;
            COND_FC: condTrue = !psr.flag;
            COND_LT: condTrue = !psr.negative && !psr.zero;
            COND_UC: condTrue = 1'b1;
            default: condTrue = 1'b0; // never
        endcase
    end

endmodule

// ==== src/instrController.sv ====
module instrController #(
    parameter int PcWaitStates = 2
) (
    input  logic                  clk,
    input  logic                  reset,
    input  ctrlPkg::opcode_t      op,
    input  ctrlPkg::opcode_t      opExt,
    input  ctrlPkg::condCode_t    cond,
    input  ctrlPkg::psrFlags_t    psr,
    output ctrlPkg::ctrlSignals_t ctrl
);
    import ctrlPkg::*;

    instrClass_t instrClass;
    condCode_t   condCode;
    logic        condTrue;

    // fields are latched on the fetch strobe the sequencer raises
    instrDecoder decoder (
        .clk        (clk),
        .reset      (reset),
        .load       (ctrl.instrWrite),
        .op         (op),
        .opExt      (opExt),
        .cond       (cond),
        .instrClass (instrClass),
        .condCode   (condCode)
    );

    condEvaluator evaluator (
        .condCode (condCode),
        .psr      (psr), // live flags, used in the transfer cycle
        .condTrue (condTrue)
    );

    ctrlSequencer #(
        .PcWaitStates (PcWaitStates)
    ) sequencer (
        .clk        (clk),
        .reset      (reset),
        .instrClass (instrClass),
        .condTrue   (condTrue),
        .ctrl       (ctrl)
    );

endmodule

// ==== src/instrDecoder.sv ====
module instrDecoder (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 load,
    input  ctrlPkg::opcode_t     op,
    input  ctrlPkg::opcode_t     opExt,
    input  ctrlPkg::condCode_t   cond,
    output ctrlPkg::instrClass_t instrClass,
    output ctrlPkg::condCode_t   condCode
);
    import ctrlPkg::*;

    opcode_t   opReg;
    opcode_t   opExtReg;
    condCode_t condReg;

    // fields are captured on the fetch strobe and held for the whole instruction
    always_ff @(posedge clk)
    begin
        if (!reset)
        begin
            opReg    <= '0; // op 0, ext 0 decodes as NOP
            opExtReg <= '0;
            condReg  <= '0;
        end
        else if (load)
        begin
            opReg    <= op;
            opExtReg <= opExt;
            condReg  <= cond;
        end
    end

    assign condCode = condReg;

    always_comb
    begin
        instrClass = NOP;
        case (opReg)
            OP_REG:
                case (opExtReg)
                    EXT_AND, EXT_OR, EXT_XOR, EXT_ADD, EXT_SUB: instrClass = ALU_REG;
                    EXT_CMP: instrClass = CMP_REG;
                    EXT_MOV: instrClass = MOV_REG;
                    default: instrClass = NOP;
                endcase
            OP_SHIFT: instrClass = (opExtReg == EXT_LSH) ? ALU_REG : ALU_IMM;
            OP_MEM:
                case (opExtReg)
                    EXT_LOAD:  instrClass = LOAD;
                    EXT_STOR:  instrClass = STOR;
                    EXT_JAL:   instrClass = JAL;
                    EXT_JCOND: instrClass = (condReg == COND_NEVER) ? NOP : JCOND;
                    default:   instrClass = NOP;
                endcase
            OP_ANDI, OP_ORI, OP_XORI, OP_ADDI, OP_SUBI, OP_LUI: instrClass = ALU_IMM;
            OP_CMPI: instrClass = CMP_IMM;
            OP_MOVI: instrClass = MOV_IMM;
            OP_BCOND: instrClass = (condReg == COND_NEVER) ? NOP : BCOND;
            default: instrClass = NOP; // undefined opcodes just step the pc
        endcase
    end

    classKnown: assert property (@(posedge clk) disable iff (!reset)
        !$isunknown(instrClass));

endmodule

// ==== verification/ctrlChecker.sv ====
module ctrlChecker (
    input  logic                  clk,
    input  logic                  reset,
    input  ctrlPkg::ctrlSignals_t ctrl,
    input  logic                  start,
    input  logic [79:0]           testName,
    input  logic [4:0]            expCycles,
    input  logic [1:0]            expRegWrites,
    input  logic [1:0]            expMemWrites,
    input  logic [1:0]            expPsrEns,
    input  logic                  expWbSel,
    input  logic                  expLinkSel,
    input  ctrlPkg::aluSrcSel_t   expSrc1,
    input  ctrlPkg::aluSrcSel_t   expSrc2,
    input  logic [1:0]            expPcEns,
    input  logic [3:0]            expPcSrcs,
    output int                    valueErrors,
    output int                    timeouts
);
    timeunit 1ns;
    timeprecision 100ps;
    import ctrlPkg::*;

    localparam int CycleLimit = 30;
    localparam ctrlSignals_t FetchOnly = '{instrWrite: 1'b1, default: '0};

    logic       active;
    logic       prevNewAlu;
    logic       wbSeen;
    logic       linkSeen;
    aluSrcSel_t src1Seen;
    aluSrcSel_t src2Seen;
    logic [3:0] pcSrcSeen; // first pc write in the low pair
    int         cycles;
    int         regWrites;
    int         memWrites;
    int         psrEns;
    int         pcEns;

    initial
    begin
        valueErrors = 0;
        timeouts    = 0;
        active      = 1'b0;
        prevNewAlu  = 1'b0;
    end

    task automatic compareField(input string what, input int expected, input int actual);
        if (expected != actual)
        begin
            $display("CHECK FAILED %0s %0s: expected %0d, actual %0d",
                     testName, what, expected, actual);
            valueErrors++;
        end
    endtask

    task automatic closeInstruction();
        compareField("cycles", expCycles, cycles);
        compareField("regWrite cycles", expRegWrites, regWrites);
        compareField("memWrite cycles", expMemWrites, memWrites);
        compareField("psrRegEn cycles", expPsrEns, psrEns);
        compareField("writeBackSelect", expWbSel, wbSeen);
        compareField("dataToWriteSelect", expLinkSel, linkSeen);
        compareField("aluSrc1Sel", expSrc1, src1Seen);
        compareField("aluSrc2Sel", expSrc2, src2Seen);
        compareField("pcEn cycles", expPcEns, pcEns);
        compareField("pcSrc list", expPcSrcs, pcSrcSeen);
    endtask

    always @(negedge clk)
    begin
        if (reset && ctrl.instrWrite)
        begin
            // a fetch cycle carries the strobe alone
            if (ctrl != FetchOnly)
            begin
                $display("CHECK FAILED fetch cycle: expected %h, actual %h", FetchOnly, ctrl);
                valueErrors++;
            end
            if (start)
            begin
                $display("test %0s: fetch strobe came again right after the fetch cycle",
                         testName);
                valueErrors++;
            end
            if (active)
                closeInstruction();
            active = 1'b0;
        end
        else if (reset)
        begin
            if (start)
            begin
                active     = 1'b1;
                cycles     = 1; // the fetch cycle already passed
                regWrites  = 0;
                memWrites  = 0;
                psrEns     = 0;
                pcEns      = 0;
                wbSeen     = 1'b0;
                linkSeen   = 1'b0;
                src1Seen   = '0;
                src2Seen   = '0;
                pcSrcSeen  = '0;
                prevNewAlu = 1'b0;
            end
            if (active)
            begin
                cycles++;
                regWrites += ctrl.regWrite;
                memWrites += ctrl.memWrite;
                psrEns    += ctrl.psrRegEn;
                wbSeen    |= ctrl.regWrite && ctrl.writeBackSelect;
                linkSeen  |= ctrl.regWrite && ctrl.dataToWriteSelect;
                if (prevNewAlu)
                begin
                    src1Seen = ctrl.aluSrc1Sel; // operands are selected after the latch
                    src2Seen = ctrl.aluSrc2Sel;
                end
                if (ctrl.pcEn)
                begin
                    if (pcEns < 2)
                        pcSrcSeen[2*pcEns +: 2] = ctrl.pcSrc;
                    pcEns++;
                end
                prevNewAlu = ctrl.newAluInput;
                if (cycles > CycleLimit)
                begin
                    $display("timeout: test %0s saw no fetch strobe within %0d cycles",
                             testName, CycleLimit);
                    timeouts++;
                    active = 1'b0;
                end
            end
        end
    end

endmodule

// ==== verification/tbInstrController.sv ====
module tbInstrController;
    timeunit 1ns;
    timeprecision 100ps;
    import ctrlPkg::*;

    localparam int PcWaits      = 2; // DUT default
    localparam int FetchTimeout = 50;
    localparam logic [127:0] HexDigits = "0123456789abcdef";

    typedef struct packed {
        logic [79:0] name;
        opcode_t     op;
        opcode_t     opExt;
        condCode_t   cond;
        psrFlags_t   psr;
        logic [4:0]  cycles;
        logic [1:0]  regWrites;
        logic [1:0]  memWrites;
        logic [1:0]  psrEns;
        logic        wbSel;
        logic        linkSel;
        aluSrcSel_t  src1;
        aluSrcSel_t  src2;
        logic [1:0]  pcEns;
        logic [3:0]  pcSrcs;
    } testRow_t;

    logic         clk = 1'b0;
    logic         reset;
    opcode_t      op;
    opcode_t      opExt;
    condCode_t    cond;
    psrFlags_t    psr;
    ctrlSignals_t ctrl;
    testRow_t     rows[$];
    testRow_t     current;
    logic         start;
    logic         stalled;
    int           stallCount;
    int           valueErrors;
    int           timeouts;

    always #2 clk = ~clk;

    instrController DUT (
        .clk   (clk),
        .reset (reset),
        .op    (op),
        .opExt (opExt),
        .cond  (cond),
        .psr   (psr),
        .ctrl  (ctrl)
    );

    ctrlChecker ctrlCheck (
        .clk          (clk),
        .reset        (reset),
        .ctrl         (ctrl),
        .start        (start),
        .testName     (current.name),
        .expCycles    (current.cycles),
        .expRegWrites (current.regWrites),
        .expMemWrites (current.memWrites),
        .expPsrEns    (current.psrEns),
        .expWbSel     (current.wbSel),
        .expLinkSel   (current.linkSel),
        .expSrc1      (current.src1),
        .expSrc2      (current.src2),
        .expPcEns     (current.pcEns),
        .expPcSrcs    (current.pcSrcs),
        .valueErrors  (valueErrors),
        .timeouts     (timeouts)
    );

    // bit i holds the outcome of condition code i
    function automatic logic condHolds(input condCode_t c, input psrFlags_t f);
        logic [15:0] holds;
        holds = {1'b0, 1'b1, f.zero | f.negative, ~f.negative & ~f.zero,
                 f.low | f.zero, ~f.low & ~f.zero, ~f.flag, f.flag,
                 ~f.negative, f.negative, ~f.low, f.low, ~f.carry, f.carry, ~f.zero, f.zero};
        return holds[c];
    endfunction

    function automatic testRow_t baseRow(input logic [79:0] name, input opcode_t opc,
                                         input opcode_t ext, input int cycles);
        testRow_t r;
        r        = '0;
        r.name   = name;
        r.op     = opc;
        r.opExt  = ext;
        r.cycles = 5'(cycles);
        r.pcEns  = 2'd1; // one sequential pc write
        return r;
    endfunction

    task automatic addAluRow(input logic [79:0] name, input opcode_t opc, input opcode_t ext,
                             input aluSrcSel_t src1, input aluSrcSel_t src2, input logic compare);
        testRow_t r;
        r           = baseRow(name, opc, ext, compare ? 5 + PcWaits : 6 + PcWaits);
        r.regWrites = compare ? 2'd0 : 2'd1;
        r.psrEns    = compare ? 2'd1 : 2'd0;
        r.src1      = src1;
        r.src2      = src2;
        rows.push_back(r);
    endtask

    task automatic addTransferRow(input logic jcond, input condCode_t c);
        testRow_t r;
        if (jcond)
            r = baseRow({"jcond ", HexDigits[8*(15-c) +: 8]}, OP_MEM, EXT_JCOND, 3 + PcWaits);
        else
            r = baseRow({"bcond ", HexDigits[8*(15-c) +: 8]}, OP_BCOND, 4'd0, 3 + PcWaits);
        r.cond = c;
        r.psr  = 8'($urandom);
        if (condHolds(c, r.psr))
            r.pcSrcs = jcond ? 4'd1 : 4'd2; // absolute or relative target
        rows.push_back(r);
    endtask

    task automatic buildTable();
        testRow_t row;
        addAluRow("and",  OP_REG,   EXT_AND, SRC1_REG,  SRC2_REG, 1'b0);
        addAluRow("add",  OP_REG,   EXT_ADD, SRC1_REG,  SRC2_REG, 1'b0);
        addAluRow("lsh",  OP_SHIFT, EXT_LSH, SRC1_REG,  SRC2_REG, 1'b0);
        addAluRow("andi", OP_ANDI,  4'd6,    SRC1_REG,  SRC2_IMM, 1'b0);
        addAluRow("addi", OP_ADDI,  4'd7,    SRC1_REG,  SRC2_IMM, 1'b0);
        addAluRow("lshi", OP_SHIFT, 4'd0,    SRC1_REG,  SRC2_IMM, 1'b0);
        addAluRow("lui",  OP_LUI,   4'd3,    SRC1_REG,  SRC2_IMM, 1'b0);
        addAluRow("mov",  OP_REG,   EXT_MOV, SRC1_ZERO, SRC2_REG, 1'b0);
        addAluRow("movi", OP_MOVI,  4'd9,    SRC1_ZERO, SRC2_IMM, 1'b0);
        addAluRow("cmp",  OP_REG,   EXT_CMP, SRC1_REG,  SRC2_REG, 1'b1);
        addAluRow("cmpi", OP_CMPI,  4'd2,    SRC1_REG,  SRC2_IMM, 1'b1);
        row           = baseRow("load", OP_MEM, EXT_LOAD, 6 + PcWaits);
        row.regWrites = 2'd1;
        row.wbSel     = 1'b1;
        rows.push_back(row);
        row           = baseRow("stor", OP_MEM, EXT_STOR, 5 + PcWaits);
        row.memWrites = 2'd1;
        rows.push_back(row);
        row           = baseRow("jal", OP_MEM, EXT_JAL, 6 + PcWaits);
        row.regWrites = 2'd1;
        row.linkSel   = 1'b1;
        row.pcEns     = 2'd2;
        row.pcSrcs    = {PC_SEQ, PC_ABS}; // target jump, then the increment
        rows.push_back(row);
        rows.push_back(baseRow("undef op", 4'd6, 4'd0, 3 + PcWaits));
        rows.push_back(baseRow("undef ext", OP_REG, 4'd0, 3 + PcWaits));
        for (int c = 0; c < 16; c++)
        begin
            addTransferRow(1'b1, 4'(c));
            addTransferRow(1'b0, 4'(c));
        end
    endtask

    task automatic waitForFetch(output logic timedOut);
        int waited;
        waited   = 0;
        timedOut = 1'b0;
        @(negedge clk);
        while (!ctrl.instrWrite && waited < FetchTimeout)
        begin
            @(negedge clk);
            waited++;
        end
        if (!ctrl.instrWrite)
        begin
            $display("timeout: no fetch strobe within %0d cycles", FetchTimeout);
            timedOut = 1'b1;
        end
    endtask

    initial
    begin
        void'($urandom(32'hfc46e0d0));
        buildTable();
        stalled    = 1'b0;
        stallCount = 0;
        start      = 1'b0;
        current    = '0;
        reset      = 1'b0;
        op         = rows[0].op;
        opExt      = rows[0].opExt;
        cond       = rows[0].cond;
        psr        = '0;
        repeat (8) @(posedge clk);
        reset <= 1'b1;
        for (int i = 0; i < rows.size() && !stalled; i++)
        begin
            waitForFetch(stalled);
            if (!stalled)
            begin
                @(posedge clk); // decoder has captured row i here
                start   <= 1'b1;
                current <= rows[i];
                psr     <= rows[i].psr;
                if (i + 1 < rows.size())
                begin
                    op    <= rows[i + 1].op;
                    opExt <= rows[i + 1].opExt;
                    cond  <= rows[i + 1].cond;
                end
                @(posedge clk);
                start <= 1'b0;
            end
        end
        if (!stalled)
            waitForFetch(stalled); // closes the last instruction
        if (stalled)
            stallCount++;
        @(posedge clk);
        $display("value errors: %0d, timeouts: %0d", valueErrors, timeouts + stallCount);
        if (valueErrors + timeouts + stallCount == 0)
            $display("No errors");
        else
            $display("Errors found");
        $finish;
    end

endmodule
